// ==== cr16_alu.sv ====
// CR16 ALU and flag register
module cr16_alu (
    input  logic             clk,
    input  logic             reset,
    input  cr16_pkg::ctrl_t  ctrl,
    input  cr16_pkg::data_t  a_val,
    input  cr16_pkg::data_t  b_val,
    output cr16_pkg::data_t  result,
    output cr16_pkg::flags_t flags
);
    import cr16_pkg::*;

    logic [DATA_W:0] sum;         // Carry out in top bit
    logic [DATA_W:0] diff;        // Borrow out in top bit
    logic            cin;         // ADDC carry in
    logic            bin;         // SUBC borrow in
    logic            is_add;
    logic            is_sub;      // SUB, SUBC, CMP
    logic            shl;         // Positive amount shifts left
    logic [4:0]      shamt;       // Shift magnitude, up to 16
    data_t           shifted;
    flags_t          next_flags;

    assign is_add = ctrl.op inside {op_add, op_addu, op_addc};
    assign is_sub = ctrl.op inside {op_sub, op_subc, op_cmp};

    assign cin  = (ctrl.op == op_addc) && flags.c;
    assign bin  = (ctrl.op == op_subc) && flags.c;
    assign sum  = {1'b0, a_val} + {1'b0, b_val} + cin;
    assign diff = {1'b0, a_val} - {1'b0, b_val} - bin;

    // Signed 5-bit shift count from b
    assign shl   = !b_val[4];
    assign shamt = b_val[4] ? (~b_val[4:0] + 5'd1) : b_val[4:0];

    always_comb begin
        if (shl) begin
            shifted = a_val << shamt;
        end else if (ctrl.op == op_ashu) begin
            shifted = data_t'($signed(a_val) >>> shamt);  // Sign fill
        end else begin
            shifted = a_val >> shamt;
        end
    end

    always_comb begin
        case (ctrl.op)
            op_add, op_addu, op_addc: result = sum[DATA_W-1:0];
            op_sub, op_subc, op_cmp:  result = diff[DATA_W-1:0];  // CMP value for z and n
            op_and:                   result = a_val & b_val;
            op_or:                    result = a_val | b_val;
            op_xor:                   result = a_val ^ b_val;
            op_not:                   result = ~b_val;
            op_mov:                   result = b_val;
            op_lsh, op_ashu:          result = shifted;
            default:                  result = a_val;  // NOP leaves rdest as is
        endcase
    end

    // Flags from this operation
    always_comb begin
        next_flags.c = is_add ? sum[DATA_W] : (is_sub ? diff[DATA_W] : 1'b0);
        next_flags.l = is_sub && (b_val > a_val);  // Unsigned compare
        next_flags.z = result == '0;
        next_flags.n = result[DATA_W-1];
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flags <= '0;
        end else if (ctrl.flag_we) begin
            flags <= next_flags;
        end
    end

endmodule

// ==== cr16_bus_port.sv ====
// PC, IR and Wishbone master port
module cr16_bus_port (
    input  logic              clk,
    input  logic              reset,
    input  cr16_pkg::bus_op_t bus_op,
    input  logic              pc_inc,
    input  cr16_pkg::data_t   mem_addr,
    input  cr16_pkg::data_t   store_data,
    input  cr16_pkg::data_t   wb_dat_r,
    input  logic              wb_ack,
    output cr16_pkg::wb_req_t wb,
    output logic              bus_done,
    output cr16_pkg::data_t   ir,
    output cr16_pkg::data_t   load_data
);
    import cr16_pkg::*;

    addr_t pc;   // Word address of the current instruction
    logic  req;  // Request open this cycle

    assign req = bus_op != bus_idle;

    // Request follows bus_op, held by the FSM until ack
    always_comb begin
        wb.cyc = req;
        wb.stb = req;
        wb.we  = bus_op == bus_write;
        wb.adr = (bus_op == bus_fetch) ? pc : addr_t'(mem_addr);  // Register address for data
        wb.dat = store_data;
    end

    assign bus_done = req && wb_ack;  // Ack ends the step

    // Program counter
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // IR feeds decode, so it comes out of reset as NOP
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= '0;
        end else if (bus_done && bus_op == bus_fetch) begin
            ir <= wb_dat_r;
        end
    end

    // Load data register
    always_ff @(posedge clk) begin
        if (bus_done && bus_op == bus_read) begin
            load_data <= wb_dat_r;  // Read back in LOAD_WB
        end
    end

endmodule

// ==== cr16_control.sv ====
// CR16 decode and control FSM
module cr16_control (
    input  logic              clk,
    input  logic              reset,
    input  cr16_pkg::data_t   ir,
    input  logic              bus_done,
    input  logic              limit_reached,
    output cr16_pkg::ctrl_t   ctrl,
    output cr16_pkg::bus_op_t bus_op,
    output logic              pc_inc,
    output logic              retire,
    output logic              halted
);
    import cr16_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_mem_read,
        st_load_wb,
        st_mem_write,
        st_halt
    } state_t;

    state_t  state;
    state_t  next_state;
    alu_op_t op;
    logic    is_rr;      // High nibble zero
    logic    is_mem;     // Memory class
    logic    is_load;
    logic    is_store;
    logic    op_writes;  // Result goes to rdest
    logic    op_flags;   // Result updates flags

    // Instruction class from the high nibble
    assign is_rr    = ir[15:12] == 4'b0000;
    assign is_mem   = ir[15:12] == 4'b0100;
    assign is_load  = is_mem && ir[7:4] == 4'b0000;
    assign is_store = is_mem && ir[7:4] == 4'b0100;

    // Opcode field, illegal codes become NOP
    always_comb begin
        logic [3:0] code;
        code = is_rr ? ir[7:4] : ir[15:12];
        case (code)
            4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b0101, 4'b0110, 4'b0111,
            4'b1000, 4'b1001, 4'b1010, 4'b1011, 4'b1100, 4'b1101:
                op = alu_op_t'(code);
            default:
                op = op_nop;
        endcase
        if (is_mem) op = op_nop;  // LOAD and STORE do no ALU work
    end

    assign op_writes = !(op inside {op_cmp, op_nop});  // CMP only sets flags
    assign op_flags  = !(op inside {op_mov, op_nop});

    // Datapath controls
    always_comb begin
        ctrl.op      = op;
        ctrl.rdest   = ir[11:8];
        ctrl.rsrc    = ir[3:0];
        ctrl.imm     = {{(DATA_W-8){ir[7]}}, ir[7:0]};  // imm8 sign-extended
        ctrl.use_imm = !is_rr && !is_mem;
        ctrl.reg_we  = (state == st_execute && op_writes) || state == st_load_wb;
        ctrl.wb_load = state == st_load_wb;
        ctrl.flag_we = state == st_execute && op_flags;
    end

    // Bus requests and retire strobes
    always_comb begin
        bus_op = bus_idle;
        pc_inc = 1'b0;
        case (state)
            st_fetch:     if (!limit_reached) bus_op = bus_fetch;  // No fetch past the limit
            st_mem_read:  bus_op = bus_read;
            st_mem_write: begin
                bus_op = bus_write;
                pc_inc = bus_done;  // Store retires on ack
            end
            st_execute,
            st_load_wb:   pc_inc = 1'b1;
            default:      bus_op = bus_idle;
        endcase
    end

    assign retire = pc_inc;  // Every retire advances the PC
    assign halted = state == st_halt;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            st_fetch: begin
                if (limit_reached) next_state = st_halt;
                else if (bus_done) next_state = st_decode;  // IR loads here
            end
            st_decode: begin
                if (is_load)       next_state = st_mem_read;
                else if (is_store) next_state = st_mem_write;
                else               next_state = st_execute;
            end
            st_execute:   next_state = st_fetch;
            st_mem_read:  if (bus_done) next_state = st_load_wb;
            st_load_wb:   next_state = st_fetch;
            st_mem_write: if (bus_done) next_state = st_fetch;
            st_halt:      next_state = st_halt;  // Stays until reset
            default:      next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== cr16_core.sv ====
// CR16 multicycle core top level
module cr16_core #(
    parameter int INSTR_LIMIT = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  cr16_pkg::data_t   wb_dat_r,
    input  logic              wb_ack,
    output cr16_pkg::wb_req_t wb,
    output cr16_pkg::flags_t  flags,
    output logic              halted
);
    import cr16_pkg::*;

    ctrl_t   ctrl;
    bus_op_t bus_op;
    logic    pc_inc;
    logic    retire;
    logic    limit_reached;
    logic    bus_done;
    data_t   ir;
    data_t   load_data;
    data_t   a_val;
    data_t   b_val;
    data_t   result;
    data_t   store_data;
    data_t   mem_addr;

    cr16_control u_control (
        .clk           (clk),
        .reset         (reset),
        .ir            (ir),
        .bus_done      (bus_done),
        .limit_reached (limit_reached),
        .ctrl          (ctrl),
        .bus_op        (bus_op),
        .pc_inc        (pc_inc),
        .retire        (retire),
        .halted        (halted)
    );

    cr16_retire_counter #(
        .INSTR_LIMIT (INSTR_LIMIT)
    ) u_retire_counter (
        .clk           (clk),
        .reset         (reset),
        .retire        (retire),
        .limit_reached (limit_reached)
    );

    cr16_bus_port u_bus_port (
        .clk        (clk),
        .reset      (reset),
        .bus_op     (bus_op),
        .pc_inc     (pc_inc),
        .mem_addr   (mem_addr),
        .store_data (store_data),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .wb         (wb),
        .bus_done   (bus_done),
        .ir         (ir),
        .load_data  (load_data)
    );

    cr16_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .result     (result),
        .load_data  (load_data),
        .a_val      (a_val),
        .b_val      (b_val),
        .store_data (store_data),
        .mem_addr   (mem_addr)
    );

    cr16_alu u_alu (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .a_val  (a_val),
        .b_val  (b_val),
        .result (result),
        .flags  (flags)
    );

endmodule

// ==== cr16_pkg.sv ====
// CR16 core shared types
package cr16_pkg;

    localparam int DATA_W = 16;  // Machine word
    localparam int ADDR_W = 16;  // Word address
    localparam int REG_W  = 4;   // Sixteen registers

    typedef logic [DATA_W-1:0] data_t;     // Register and bus data
    typedef logic [ADDR_W-1:0] addr_t;     // Word address on the bus
    typedef logic [REG_W-1:0]  reg_idx_t;  // Register file index

    // ALU opcodes, CR16 encoding
    typedef enum logic [3:0] {
        op_nop  = 4'b0000,
        op_and  = 4'b0001,
        op_or   = 4'b0010,
        op_xor  = 4'b0011,
        op_lsh  = 4'b0100,  // RR form only, 0100 immediate is memory class
        op_add  = 4'b0101,
        op_addu = 4'b0110,
        op_addc = 4'b0111,
        op_not  = 4'b1000,
        op_sub  = 4'b1001,
        op_subc = 4'b1010,
        op_cmp  = 4'b1011,
        op_ashu = 4'b1100,
        op_mov  = 4'b1101
    } alu_op_t;

    // Kind of bus request this cycle
    typedef enum logic [1:0] {bus_idle, bus_fetch, bus_read, bus_write} bus_op_t;

    // Condition flags
    typedef struct packed {
        logic c;  // Carry or borrow
        logic l;  // Unsigned less
        logic z;  // Zero
        logic n;  // Negative
    } flags_t;

    // Decoder to datapath
    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rdest;    // Destination, also store data
        reg_idx_t rsrc;     // Source, also address register
        data_t    imm;      // Sign-extended imm8
        logic     use_imm;  // B operand from imm
        logic     reg_we;
        logic     wb_load;  // Write back load data
        logic     flag_we;
    } ctrl_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } wb_req_t;

endpackage

// ==== cr16_regfile.sv ====
// CR16 register file
module cr16_regfile (
    input  logic            clk,
    input  logic            reset,
    input  cr16_pkg::ctrl_t ctrl,
    input  cr16_pkg::data_t result,
    input  cr16_pkg::data_t load_data,
    output cr16_pkg::data_t a_val,
    output cr16_pkg::data_t b_val,
    output cr16_pkg::data_t store_data,
    output cr16_pkg::data_t mem_addr
);
    import cr16_pkg::*;

    data_t regs [2**REG_W];

    // Destination doubles as first operand
    assign a_val      = regs[ctrl.rdest];
    assign b_val      = ctrl.use_imm ? ctrl.imm : regs[ctrl.rsrc];
    assign store_data = regs[ctrl.rdest];  // STORE data register
    assign mem_addr   = regs[ctrl.rsrc];   // LOAD/STORE address register

    // Write-back from ALU or load register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we) begin
            regs[ctrl.rdest] <= ctrl.wb_load ? load_data : result;
        end
    end

endmodule

// ==== cr16_retire_counter.sv ====
// Retired instruction counter
module cr16_retire_counter #(
    parameter int INSTR_LIMIT = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic retire,
    output logic limit_reached
);

    localparam int CNT_W = (INSTR_LIMIT > 0) ? $clog2(INSTR_LIMIT + 1) : 1;
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(INSTR_LIMIT);

    logic [CNT_W-1:0] count;  // Instructions retired so far

    assign limit_reached = count == LIMIT;

    // Saturates at the limit
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (retire && !limit_reached) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== filelist.f ====
cr16_pkg.sv
cr16_control.sv
cr16_retire_counter.sv
cr16_bus_port.sv
cr16_regfile.sv
cr16_alu.sv
cr16_core.sv
tb_cr16_clock.sv
tb_cr16_memory.sv
tb_cr16.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CR16 simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_cr16 -f filelist.f -o sim_cr16 \
    && ./obj_dir/sim_cr16 > sim.log \
    || echo "Build or simulation error"
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tb_cr16.sv ====
// CR16 core testbench
module tb_cr16;
    timeunit 1ns;
    timeprecision 100ps;
    import cr16_pkg::*;

    localparam int INSTR_LIMIT = 16;
    localparam int NUM_TESTS   = 6;

    logic    clk;
    logic    reset;
    logic    zero_wait;
    wb_req_t wb;
    data_t   wb_dat_r;
    logic    wb_ack;
    flags_t  flags;
    logic    halted;
    int      proto_errors;    // Wishbone rule breaks seen by the slave

    data_t  prog [INSTR_LIMIT];
    data_t  m_regs [16];      // Model state
    data_t  m_mem [256];
    flags_t m_flags;
    addr_t  exp_adr [$];      // Predicted writes
    data_t  exp_dat [$];
    data_t  observed [$];
    data_t  first_run [$];    // Writes of the waited run
    int     n_stores;
    int     n_loads;
    int     writes;
    int     reads;
    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;

    tb_cr16_clock u_clk (.clk(clk), .reset(reset));

    tb_cr16_memory u_mem (
        .clk          (clk),
        .reset        (reset),
        .zero_wait    (zero_wait),
        .wb           (wb),
        .dat_r        (wb_dat_r),
        .ack          (wb_ack),
        .proto_errors (proto_errors)
    );

    cr16_core #(.INSTR_LIMIT(INSTR_LIMIT)) UUT (
        .clk      (clk),
        .reset    (reset),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb       (wb),
        .flags    (flags),
        .halted   (halted)
    );

    initial zero_wait = 1'b0;

    task check(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Instruction encoders
    function automatic data_t rr_form(alu_op_t op, reg_idx_t rd, reg_idx_t rs);
        return {4'h0, rd, op, rs};
    endfunction

    function automatic data_t imm_form(alu_op_t op, reg_idx_t rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic data_t load_form(reg_idx_t rd, reg_idx_t ra);
        return {4'h4, rd, 4'h0, ra};
    endfunction

    function automatic data_t store_form(reg_idx_t rd, reg_idx_t ra);
        return {4'h4, rd, 4'h4, ra};
    endfunction

    // Data fill, mixes every address bit
    function automatic data_t fill_word(input int a);
        logic [31:0] t;
        t = a * 32'h9E37 + 32'h1357;
        return t[15:0] ^ t[31:16];
    endfunction

    // Reference model of one instruction
    function automatic void ref_step(input data_t instr);
        logic [3:0]  code;
        reg_idx_t    rd;
        reg_idx_t    rs;
        data_t       a;
        data_t       b;
        data_t       res;
        logic [16:0] wide;
        logic        do_write;
        logic        do_flags;
        int          sh;
        rd = instr[11:8];
        rs = instr[3:0];
        if (instr[15:12] == 4'h4) begin  // Memory class
            if (instr[7:4] == 4'h0) begin
                m_regs[rd] = m_mem[m_regs[rs][7:0]];
                n_loads++;
            end else if (instr[7:4] == 4'h4) begin
                exp_adr.push_back(m_regs[rs]);
                exp_dat.push_back(m_regs[rd]);
                m_mem[m_regs[rs][7:0]] = m_regs[rd];
                n_stores++;
            end
            return;
        end
        code     = (instr[15:12] == 4'h0) ? instr[7:4] : instr[15:12];
        a        = m_regs[rd];
        b        = (instr[15:12] == 4'h0) ? m_regs[rs] : {{8{instr[7]}}, instr[7:0]};
        res      = a;
        do_write = 1'b1;
        do_flags = 1'b1;
        wide     = '0;
        case (code)
            op_add, op_addu, op_addc: begin
                wide = {1'b0, a} + {1'b0, b} + {16'h0, code == op_addc && m_flags.c};
                res  = wide[15:0];
            end
            op_sub, op_subc, op_cmp: begin
                wide     = {1'b0, a} - {1'b0, b} - {16'h0, code == op_subc && m_flags.c};
                res      = wide[15:0];
                do_write = code != op_cmp;  // Compare only
            end
            op_and: res = a & b;
            op_or:  res = a | b;
            op_xor: res = a ^ b;
            op_not: res = ~b;
            op_mov: begin
                res      = b;
                do_flags = 1'b0;
            end
            op_lsh, op_ashu: begin
                sh = b[4] ? int'(b[4:0]) - 32 : int'(b[4:0]);  // Signed count
                if (sh >= 0) res = a << sh;
                else if (code == op_ashu) res = data_t'($signed(a) >>> (-sh));
                else res = a >> (-sh);
            end
            default: begin  // NOP and unused codes
                do_write = 1'b0;
                do_flags = 1'b0;
            end
        endcase
        if (do_write) m_regs[rd] = res;
        if (do_flags) begin
            m_flags.c = wide[16];
            m_flags.l = (code inside {op_sub, op_subc, op_cmp}) && (b > a);
            m_flags.z = res == '0;
            m_flags.n = res[15];
        end
    endfunction

    task build_program(input int id);
        case (id)
            1: prog = '{imm_form(op_mov, 4'd15, 8'h40), imm_form(op_mov, 4'd1, 8'h5A),
                        imm_form(op_mov, 4'd2, 8'hFD), rr_form(op_add, 4'd1, 4'd2),
                        store_form(4'd1, 4'd15), imm_form(op_xor, 4'd2, 8'h33),
                        rr_form(op_and, 4'd1, 4'd2), store_form(4'd1, 4'd15),
                        imm_form(op_or, 4'd3, 8'h81), rr_form(op_lsh, 4'd3, 4'd2),
                        store_form(4'd3, 4'd15), imm_form(op_ashu, 4'd1, 8'hFC),
                        rr_form(op_not, 4'd4, 4'd1), store_form(4'd4, 4'd15),
                        imm_form(op_sub, 4'd4, 8'h07), store_form(4'd4, 4'd15)};
            2: prog = '{imm_form(op_mov, 4'd15, 8'h50), imm_form(op_mov, 4'd1, 8'hFF),
                        imm_form(op_add, 4'd1, 8'h01), imm_form(op_addc, 4'd2, 8'h05),
                        store_form(4'd2, 4'd15), imm_form(op_mov, 4'd3, 8'h02),
                        imm_form(op_sub, 4'd3, 8'h05), imm_form(op_subc, 4'd4, 8'h01),
                        store_form(4'd4, 4'd15), rr_form(op_addu, 4'd3, 4'd4),
                        store_form(4'd3, 4'd15), rr_form(op_subc, 4'd3, 4'd1),
                        store_form(4'd3, 4'd15), rr_form(op_addc, 4'd1, 4'd1),
                        store_form(4'd1, 4'd15), store_form(4'd3, 4'd15)};
            3: prog = '{imm_form(op_mov, 4'd1, 8'h10), imm_form(op_mov, 4'd2, 8'h20),
                        rr_form(op_add, 4'd1, 4'd2), imm_form(op_mov, 4'd15, 8'h60),
                        store_form(4'd1, 4'd15), imm_form(op_xor, 4'd1, 8'h0F),
                        imm_form(op_sub, 4'd2, 8'h01), rr_form(op_or, 4'd2, 4'd1),
                        store_form(4'd2, 4'd15), imm_form(op_cmp, 4'd2, 8'h30),
                        imm_form(op_ashu, 4'd2, 8'h02), store_form(4'd2, 4'd15),
                        imm_form(op_add, 4'd1, 8'h00), rr_form(op_cmp, 4'd1, 4'd2),
                        rr_form(op_nop, 4'd0, 4'd0), imm_form(op_mov, 4'd5, 8'h7F)};
            default: prog = '{imm_form(op_mov, 4'd14, 8'h90), load_form(4'd1, 4'd14),
                        imm_form(op_mov, 4'd13, 8'h70), store_form(4'd1, 4'd13),
                        imm_form(op_add, 4'd14, 8'h01), load_form(4'd2, 4'd14),
                        rr_form(op_add, 4'd2, 4'd1), imm_form(op_add, 4'd13, 8'h01),
                        store_form(4'd2, 4'd13), load_form(4'd3, 4'd13),
                        imm_form(op_xor, 4'd3, 8'h55), imm_form(op_add, 4'd13, 8'h01),
                        store_form(4'd3, 4'd13), load_form(4'd4, 4'd13),
                        imm_form(op_add, 4'd13, 8'h01), store_form(4'd4, 4'd13)};
        endcase
    endtask

    // Compare each bus write with the next predicted one
    always @(u_mem.write_seen) begin
        writes++;
        observed.push_back(u_mem.last_dat);
        if (exp_adr.size() == 0) begin
            errors++;
            $display("Unexpected bus write to address 0x%h", u_mem.last_adr);
        end else begin
            check("wb.adr", u_mem.last_adr, exp_adr.pop_front());
            check("wb.dat", u_mem.last_dat, exp_dat.pop_front());
        end
    end

    // Completed reads, fetches and loads alike
    always @(negedge clk) begin
        if (reset && wb.cyc && wb_ack && !wb.we) reads++;
    end

    task run_test(input int num, input string name, input int id, input logic zw);
        int errors_before;
        int proto_before;
        int late_cyc;
        errors_before = errors;
        proto_before  = proto_errors;
        late_cyc      = 0;
        build_program(id);
        zero_wait = zw;
        for (int a = 0; a < 256; a++) begin
            m_mem[a] = (a < INSTR_LIMIT) ? prog[a] : fill_word(a);
            u_mem.preload(a, m_mem[a]);
        end
        foreach (m_regs[i]) m_regs[i] = '0;
        m_flags  = '0;
        n_stores = 0;
        n_loads  = 0;
        exp_adr.delete();
        exp_dat.delete();
        for (int i = 0; i < INSTR_LIMIT; i++) ref_step(prog[i]);
        u_clk.apply_reset();
        writes = 0;
        reads  = 0;
        observed.delete();
        while (!halted) @(negedge clk);
        check("flags", {12'h0, flags}, {12'h0, m_flags});
        // One fetch per instruction plus one read per LOAD
        check("read count", 16'(reads), 16'(INSTR_LIMIT + n_loads));
        repeat (50) begin
            @(negedge clk);
            if (wb.cyc) late_cyc++;
        end
        if (late_cyc != 0) begin
            errors++;
            $display("Bus cycle started after halt");
        end
        check("write count", 16'(writes), 16'(n_stores));
        if (proto_errors != proto_before) begin
            errors++;
            $display("Wishbone request changed or dropped before ack");
        end
        if (num == 1) first_run = observed;
        if (num == 5) begin  // Same program, zero wait states
            check("write count vs waited run", 16'(observed.size()), 16'(first_run.size()));
            foreach (observed[i]) begin
                if (i < first_run.size()) check("wb.dat vs waited run", observed[i], first_run[i]);
            end
        end
        tests++;
        $display("Test %0d %s: %s", num, name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        run_test(1, "alu results", 1, 1'b0);
        run_test(2, "carry chain", 2, 1'b0);
        run_test(3, "flags after cmp", 3, 1'b0);
        run_test(4, "load then store", 4, 1'b0);
        run_test(5, "back-pressure", 1, 1'b1);
        run_test(6, "retire limit", 4, 1'b1);
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, 40 cycles per instruction per test
    initial begin
        repeat (NUM_TESTS * INSTR_LIMIT * 40) @(posedge clk);
        $display("Timeout: the core did not halt in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== tb_cr16_clock.sv ====
// Testbench clock and reset
module tb_cr16_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk   = 1'b0;
        reset = 1'b0;  // Held from time zero
    end

    always #2 clk = ~clk;  // 4 ns period

    // Eight cycles of reset, released 1 ns after an edge
    task apply_reset();
        @(posedge clk);
        #1 reset = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b1;
    endtask

endmodule

// ==== tb_cr16_memory.sv ====
// Wishbone slave memory model
module tb_cr16_memory (
    input  logic              clk,
    input  logic              reset,
    input  logic              zero_wait,    // Ack without wait states
    input  cr16_pkg::wb_req_t wb,
    output cr16_pkg::data_t   dat_r,
    output logic              ack,
    output int                proto_errors  // Request changed or dropped early
);
    timeunit 1ns;
    timeprecision 100ps;
    import cr16_pkg::*;

    data_t  mem [256];
    integer seed = 32'hfa20;
    int     waits;      // Wait states left
    logic   busy;       // Request accepted, not yet acked
    addr_t  held_adr;
    logic   held_we;
    data_t  held_dat;
    addr_t  last_adr;   // Last completed write
    data_t  last_dat;
    event   write_seen;

    initial begin
        ack          = 1'b0;
        dat_r        = '0;
        busy         = 1'b0;
        waits        = 0;
        proto_errors = 0;
    end

    task preload(input int a, input data_t d);
        mem[a[7:0]] = d;
    endtask

    // Responds 1 ns after the edge, once the request has settled
    always @(posedge clk) begin
        #1;
        if (!reset) begin
            ack  = 1'b0;
            busy = 1'b0;
        end else begin
            if (ack) ack = 1'b0;  // Taken by the master on this edge
            if (wb.cyc && wb.stb) begin
                if (!busy) begin
                    busy     = 1'b1;
                    held_adr = wb.adr;
                    held_we  = wb.we;
                    held_dat = wb.dat;
                    waits    = zero_wait ? 0 : {$random(seed)} % 4;
                end else if (wb.adr != held_adr || wb.we != held_we || wb.dat != held_dat) begin
                    proto_errors++;
                end
                if (waits == 0) begin
                    busy = 1'b0;
                    ack  = 1'b1;
                    if (held_we) begin
                        mem[held_adr[7:0]] = held_dat;
                        last_adr = held_adr;
                        last_dat = held_dat;
                        ->write_seen;
                    end else begin
                        dat_r = mem[held_adr[7:0]];
                    end
                end else begin
                    waits--;
                end
            end else if (busy) begin
                proto_errors++;  // Dropped before ack
                busy = 1'b0;
            end
        end
    end

endmodule
